// File: Makefile
# Verilator build and run for the Wishbone SoC core testbench

VERILATOR ?= verilator
TOP       ?= tb_soc
FILELIST  ?= soc_sys.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
RUN_FLAGS ?= +verilator+error+limit+100
FAIL_MSG  ?= Regression failed
PASS_MSG  ?= Regression passed

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM) $(RUN_FLAGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported failure, see $(LOG)"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: sim/soc_assertions.sv
// Bus response and SRAM strobe checks, bound into the decoder and the SRAM controller
// Ports that do not exist at a bind target are tied to their idle levels

`timescale 1ns/1ns

module soc_assertions (
  input logic sysclk,
  input logic reset_switch,
  input logic ack_i,
  input logic err_i,
  input logic ce_n_i,
  input logic we_n_i,
  input logic oe_n_i,
  input logic dq_oe_i
);

  int unsigned fail_cnt = 0;    // Failed assertions so far

  // --------------------------------------------------------------------------
  // Bus response
  // --------------------------------------------------------------------------
  a_ack_err: assert property (@(posedge sysclk) disable iff (reset_switch)
                              !(ack_i && err_i))
    else
    begin
      fail_cnt++;
      $error("ack and err high in the same cycle");
    end

  // --------------------------------------------------------------------------
  // SRAM strobes
  // --------------------------------------------------------------------------
  a_we_ce: assert property (@(posedge sysclk) disable iff (reset_switch) !we_n_i |-> !ce_n_i)
    else
    begin
      fail_cnt++;
      $error("SRAM we_n low while ce_n is high");
    end

  a_oe_we: assert property (@(posedge sysclk) disable iff (reset_switch)
                            !(!oe_n_i && !we_n_i))
    else
    begin
      fail_cnt++;
      $error("SRAM oe_n and we_n low together");
    end

  // Data driven only in a write cycle, chip on and outputs off
  a_dq_oe: assert property (@(posedge sysclk) disable iff (reset_switch)
                            dq_oe_i |-> (oe_n_i && !ce_n_i))
    else
    begin
      fail_cnt++;
      $error("SRAM data driven outside a write cycle");
    end

endmodule

bind wb_decoder soc_assertions u_dec_chk (
  .sysclk       (sysclk),
  .reset_switch (reset_switch),
  .ack_i        (host_ack_o),
  .err_i        (host_err_o),
  .ce_n_i       (1'b1),
  .we_n_i       (1'b1),
  .oe_n_i       (1'b1),
  .dq_oe_i      (1'b0)
);

bind sram_ctrl soc_assertions u_sram_chk (
  .sysclk       (sysclk),
  .reset_switch (reset_switch),
  .ack_i        (1'b0),
  .err_i        (1'b0),
  .ce_n_i       (sram_ce_n_o),
  .we_n_i       (sram_we_n_o),
  .oe_n_i       (sram_oe_n_o),
  .dq_oe_i      (sram_dq_oe_o)
);

// File: sim/soc_input.txt
# Columns: name op addr sel rnd data expect pad aux, all hex except rnd
# op is write, read, rderr, wrerr or pads; rnd 1 gives random write data or a predicted read
# pads drives pad and aux inputs, then checks gpio_pad_o against expect and gpio_padoe_o against data
rst_pads    pads  00000000 0 0 00000000 00000000 00000000 00000000
rst_oe      read  00100004 f 0 00000000 00000000 00000000 00000000
rt_wr0      write 00000000 f 1 00000000 00000000 00000000 00000000
rt_wr1      write 00000004 f 1 00000000 00000000 00000000 00000000
rt_wr2      write 00000008 f 1 00000000 00000000 00000000 00000000
rt_wr3      write 0003fffc f 1 00000000 00000000 00000000 00000000
rt_wr4      write 0007fffc f 1 00000000 00000000 00000000 00000000
rt_rd0      read  00000000 f 1 00000000 00000000 00000000 00000000
rt_rd1      read  00000004 f 1 00000000 00000000 00000000 00000000
rt_rd2      read  00000008 f 1 00000000 00000000 00000000 00000000
rt_rd3      read  0003fffc f 1 00000000 00000000 00000000 00000000
rt_rd4      read  0007fffc f 1 00000000 00000000 00000000 00000000
ln_full     write 00000100 f 0 11223344 00000000 00000000 00000000
ln_half     write 00000100 5 0 aabbccdd 00000000 00000000 00000000
ln_rd       read  00000100 f 0 00000000 11bb33dd 00000000 00000000
go_out      write 00100000 f 0 a5a5f00f 00000000 00000000 00000000
go_oe       write 00100004 f 0 ffff00ff 00000000 00000000 00000000
go_aux      write 00100008 f 0 00ff00ff 00000000 00000000 00000000
go_pads     pads  00000000 0 0 ffff00ff a534f078 00000000 12345678
gi_pads     pads  00000000 0 0 ffff00ff a534f078 c3c35a5a 12345678
gi_rd       read  0010000c f 0 00000000 c3c35a5a 00000000 00000000
gi_wr       write 0010000c f 0 ffffffff 00000000 00000000 00000000
gi_rd2      read  0010000c f 0 00000000 c3c35a5a 00000000 00000000
un_rd       rderr 00200000 f 0 00000000 00000000 00000000 00000000
un_wr_sram  wrerr 00200004 f 0 deadbeef 00000000 00000000 00000000
un_wr_gpio  wrerr 00200000 f 0 ffffffff 00000000 00000000 00000000
un_chk_sram read  00000004 f 1 00000000 00000000 00000000 00000000
un_chk_oe   read  00100004 f 0 00000000 ffff00ff 00000000 00000000
un_chk_out  read  00100000 f 0 00000000 a5a5f00f 00000000 00000000

// File: sim/sram_model.sv
// Behavioral 256K x 16 asynchronous SRAM for the split data ports of soc_top
// Writes land on the rising edge of we_n, reads are combinational

`timescale 1ns/1ns

module sram_model (
  input  soc_pkg::sram_adr_t sram_addr_i,
  input  soc_pkg::sram_dat_t sram_dq_i,     // Write data from the controller
  input  logic               sram_dq_oe_i,
  output soc_pkg::sram_dat_t sram_dq_o,     // Read data to the controller
  input  logic               sram_ub_n_i,
  input  logic               sram_lb_n_i,
  input  logic               sram_we_n_i,
  input  logic               sram_ce_n_i,
  input  logic               sram_oe_n_i
);
  import soc_pkg::*;

  sram_dat_t mem [0:(1<<18)-1];

  // Byte lanes written under ub_n and lb_n
  always @(posedge sram_we_n_i)
  begin
    if (!sram_ce_n_i && sram_dq_oe_i)
    begin
      if (!sram_lb_n_i)
        mem[sram_addr_i][7:0] <= sram_dq_i[7:0];
      if (!sram_ub_n_i)
        mem[sram_addr_i][15:8] <= sram_dq_i[15:8];
    end
  end

  assign sram_dq_o = (!sram_ce_n_i && !sram_oe_n_i) ?
                     {sram_ub_n_i ? 8'h00 : mem[sram_addr_i][15:8],
                      sram_lb_n_i ? 8'h00 : mem[sram_addr_i][7:0]} : 16'h0000;  // Idle bus

endmodule

// File: sim/tb_soc.sv
// Testbench for soc_top, runs the operations listed in sim/soc_input.txt
// Drives the Wishbone host port and GPIO pads, with a behavioral SRAM on the pins

`timescale 1ns/1ns

module tb_soc;
  import soc_pkg::*;

  localparam int    CLK_PERIOD = 100;
  localparam int    RST_CYCLES = 8;
  localparam int    CYC_PER_OP = 20;                    // Watchdog budget per file line
  localparam int    ACK_LIMIT  = 16;                    // Cycles to wait for ack or err
  localparam string TEST_FILE  = "sim/soc_input.txt";

  typedef logic [16:0] word_idx_t;                      // SRAM word, address bits 18:2

  typedef struct {
    string     name;
    string     op;        // write, read, rderr, wrerr or pads
    wb_adr_t   adr;
    wb_sel_t   sel;
    logic      rnd;       // Random data or predicted read
    wb_dat_t   dat;
    wb_dat_t   exp;
    gpio_vec_t pad;
    gpio_vec_t aux;
  } test_op_t;

  logic        sysclk;
  logic        reset_switch;
  logic        host_cyc;
  logic        host_stb;
  logic        host_we;
  wb_adr_t     host_adr;
  wb_dat_t     host_wdat;
  wb_sel_t     host_sel;
  wb_dat_t     host_rdat;
  logic        host_ack;
  logic        host_err;
  gpio_vec_t   gpio_aux;
  gpio_vec_t   gpio_pad_in;
  gpio_vec_t   gpio_pad_out;
  gpio_vec_t   gpio_padoe;
  sram_adr_t   sram_addr;
  sram_dat_t   sram_dq_rd;    // Memory to controller
  sram_dat_t   sram_dq_wr;    // Controller to memory
  logic        sram_dq_oe;
  logic        sram_ub_n;
  logic        sram_lb_n;
  logic        sram_we_n;
  logic        sram_ce_n;
  logic        sram_oe_n;

  test_op_t    ops[$];
  wb_dat_t     ref_mem [word_idx_t];                    // Expected SRAM contents
  logic        loaded;
  int          dat_errs   = 0;
  int          pad_errs   = 0;
  int          flag_errs  = 0;
  int          other_errs = 0;
  int unsigned asrt_fails;

  soc_top u_dut (
    .sysclk       (sysclk),
    .reset_switch (reset_switch),
    .host_cyc_i   (host_cyc),
    .host_stb_i   (host_stb),
    .host_we_i    (host_we),
    .host_adr_i   (host_adr),
    .host_dat_i   (host_wdat),
    .host_sel_i   (host_sel),
    .host_dat_o   (host_rdat),
    .host_ack_o   (host_ack),
    .host_err_o   (host_err),
    .gpio_aux_i   (gpio_aux),
    .gpio_pad_i   (gpio_pad_in),
    .gpio_pad_o   (gpio_pad_out),
    .gpio_padoe_o (gpio_padoe),
    .sram_addr_o  (sram_addr),
    .sram_dq_i    (sram_dq_rd),
    .sram_dq_o    (sram_dq_wr),
    .sram_dq_oe_o (sram_dq_oe),
    .sram_ub_n_o  (sram_ub_n),
    .sram_lb_n_o  (sram_lb_n),
    .sram_we_n_o  (sram_we_n),
    .sram_ce_n_o  (sram_ce_n),
    .sram_oe_n_o  (sram_oe_n)
  );

  sram_model u_sram_mem (
    .sram_addr_i  (sram_addr),
    .sram_dq_i    (sram_dq_wr),
    .sram_dq_oe_i (sram_dq_oe),
    .sram_dq_o    (sram_dq_rd),
    .sram_ub_n_i  (sram_ub_n),
    .sram_lb_n_i  (sram_lb_n),
    .sram_we_n_i  (sram_we_n),
    .sram_ce_n_i  (sram_ce_n),
    .sram_oe_n_i  (sram_oe_n)
  );

  initial
  begin
    sysclk = 1'b0;
    forever #(CLK_PERIOD/2) sysclk = ~sysclk;
  end

  // --------------------------------------------------------------------------
  // Compare tasks
  // --------------------------------------------------------------------------
  task automatic check_dat(input string name, input wb_dat_t exp, input wb_dat_t act);
    if (act !== exp)
    begin
      dat_errs++;
      $display("error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_pad(input string name, input string what, input gpio_vec_t exp,
                           input gpio_vec_t act);
    if (act !== exp)
    begin
      pad_errs++;
      $display("error %s %s: expected %h, actual %h", name, what, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input string what, input logic exp,
                            input logic act);
    if (act !== exp)
    begin
      flag_errs++;
      $display("error %s %s: expected %b, actual %b", name, what, exp, act);
    end
  endtask

  // Byte lanes of new_word replace old_word where sel is set
  function automatic wb_dat_t apply_lanes(input wb_dat_t old_word, input wb_dat_t new_word,
                                          input wb_sel_t sel);
    wb_dat_t res;
    for (int i = 0; i < 4; i++)
      res[8*i +: 8] = sel[i] ? new_word[8*i +: 8] : old_word[8*i +: 8];
    return res;
  endfunction

  // --------------------------------------------------------------------------
  // Data file reader
  // --------------------------------------------------------------------------
  task automatic load_tests();
    int        fd;
    int        n;
    int        rnd;
    string     line;
    string     nm;
    string     op;
    wb_adr_t   adr;
    wb_sel_t   sel;
    wb_dat_t   dat;
    wb_dat_t   exp;
    gpio_vec_t pad;
    gpio_vec_t aux;
    test_op_t  t;
    fd = $fopen(TEST_FILE, "r");
    if (fd == 0)
    begin
      other_errs++;
      $display("Cannot open the test file %s", TEST_FILE);
      return;
    end
    while (!$feof(fd))
    begin
      n = $fgets(line, fd);
      if (n > 1 && line[0] != "#")                    // Skip comments and empty lines
      begin
        n = $sscanf(line, "%s %s %h %h %d %h %h %h %h", nm, op, adr, sel, rnd, dat, exp,
                    pad, aux);
        if (n == 9)
        begin
          t = '{nm, op, adr, sel, rnd != 0, dat, exp, pad, aux};
          ops.push_back(t);
        end
        else if (n > 0)
        begin
          other_errs++;
          $display("Malformed line in the test file: %s", line);
        end
      end
    end
    $fclose(fd);
    if (ops.size() == 0)
    begin
      other_errs++;
      $display("The test file holds no operations");
    end
  endtask

  // --------------------------------------------------------------------------
  // Host bus driver, Wishbone classic
  // --------------------------------------------------------------------------
  task automatic bus_access(input logic we, input wb_adr_t adr, input wb_sel_t sel,
                            input wb_dat_t wdat, output wb_dat_t rdat, output logic ack,
                            output logic err);
    int waited;
    waited = 0;
    @(negedge sysclk);
    host_cyc  = 1'b1;
    host_stb  = 1'b1;
    host_we   = we;
    host_adr  = adr;
    host_wdat = wdat;
    host_sel  = sel;
    @(negedge sysclk);
    while (!(host_ack | host_err) && waited < ACK_LIMIT)
    begin
      @(negedge sysclk);
      waited++;
    end
    ack  = host_ack;                                   // Mid-cycle, stable
    err  = host_err;
    rdat = host_rdat;
    if (!(ack | err))
    begin
      other_errs++;
      $display("No ack or err from address %h within %0d cycles", adr, ACK_LIMIT);
    end
    @(negedge sysclk);                                 // Rising edge in between ends it
    host_cyc = 1'b0;
    host_stb = 1'b0;
    host_we  = 1'b0;
  endtask

  // One line of the data file
  task automatic run_op(input test_op_t t);
    wb_dat_t   wdat;
    wb_dat_t   rdat;
    wb_dat_t   exp;
    word_idx_t word;
    logic      ack;
    logic      err;
    logic      is_wr;
    logic      bad;
    word  = t.adr[18:2];
    wdat  = t.rnd ? $urandom : t.dat;
    exp   = t.exp;
    is_wr = (t.op == "write") || (t.op == "wrerr");
    bad   = (t.op == "rderr") || (t.op == "wrerr");
    if (t.op == "pads")
    begin
      @(negedge sysclk);
      gpio_pad_in = t.pad;
      gpio_aux    = t.aux;
      repeat (3) @(negedge sysclk);                    // Two sync flops plus one spare
      check_pad(t.name, "pad_o", t.exp, gpio_pad_out);
      check_pad(t.name, "padoe_o", t.dat, gpio_padoe);
    end
    else if (is_wr || bad || t.op == "read")
    begin
      bus_access(is_wr, t.adr, t.sel, wdat, rdat, ack, err);
      check_flag(t.name, "ack", !bad, ack);
      check_flag(t.name, "err", bad, err);
      if (is_wr && !bad && t.adr[23:20] == REGION_SRAM)
        ref_mem[word] = apply_lanes(ref_mem.exists(word) ? ref_mem[word] : '0, wdat, t.sel);
      if (!is_wr)
      begin
        if (t.rnd && ref_mem.exists(word))
          exp = ref_mem[word];                         // Predicted from earlier writes
        else if (t.rnd)
        begin
          other_errs++;
          $display("Test %s reads an SRAM word that was never written", t.name);
        end
        check_dat(t.name, exp, rdat);
      end
    end
    else
    begin
      other_errs++;
      $display("Test %s has an unknown operation %s", t.name, t.op);
    end
  endtask

  // --------------------------------------------------------------------------
  // Main sequence and watchdog
  // --------------------------------------------------------------------------
  initial
  begin
    loaded       = 1'b0;
    reset_switch = 1'b1;
    host_cyc     = 1'b0;
    host_stb     = 1'b0;
    host_we      = 1'b0;
    host_adr     = '0;
    host_wdat    = '0;
    host_sel     = '0;
    gpio_aux     = '0;
    gpio_pad_in  = '0;
    void'($urandom(32'h1d49));
    load_tests();
    loaded = 1'b1;
    repeat (RST_CYCLES) @(negedge sysclk);
    reset_switch = 1'b0;
    foreach (ops[i])
      run_op(ops[i]);
    repeat (2) @(negedge sysclk);
    asrt_fails = u_dut.u_sram.u_sram_chk.fail_cnt + u_dut.u_decoder.u_dec_chk.fail_cnt;
    $display("Errors: data %0d, pad %0d, flag %0d, other %0d, assertion %0d",
             dat_errs, pad_errs, flag_errs, other_errs, asrt_fails);
    if (dat_errs + pad_errs + flag_errs + other_errs + asrt_fails == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

  initial
  begin
    wait (loaded);
    repeat (ops.size() * CYC_PER_OP + RST_CYCLES + 4) @(posedge sysclk);
    $display("Watchdog expired before all operations completed");
    $display("Regression failed");
    $finish;
  end

endmodule

// File: soc_sys.f
verilog/soc_pkg.sv
verilog/wb_if.sv
verilog/wb_decoder.sv
verilog/gpio_port.sv
verilog/sram_ctrl.sv
verilog/soc_top.sv
sim/sram_model.sv
sim/soc_assertions.sv
sim/tb_soc.sv

// File: verilog/gpio_port.sv
// 32-bit GPIO slave with OUT, OE and AUX registers and a synchronized IN port
// Pads with their AUX bit set take the aux input instead of OUT

`timescale 1ns/1ns

module gpio_port (
  input  logic               sysclk,
  input  logic               reset_switch,
  wb_if.slave                bus,
  input  soc_pkg::gpio_vec_t gpio_aux_i,
  input  soc_pkg::gpio_vec_t gpio_pad_i,
  output soc_pkg::gpio_vec_t gpio_pad_o,
  output soc_pkg::gpio_vec_t gpio_padoe_o
);
  import soc_pkg::*;

  gpio_vec_t out_q;     // OUT register
  gpio_vec_t oe_q;      // OE register
  gpio_vec_t aux_q;     // AUX select register
  gpio_vec_t in_meta_q; // First sync stage
  gpio_vec_t in_q;      // Second sync stage, read as IN
  logic      ack_q;
  logic      access;    // First edge of a request
  logic      wr_en;
  reg_ofs_t  reg_ofs;

  // Byte-lane merge of new data into a register
  function automatic wb_dat_t lane_merge(
    input wb_dat_t old_val,
    input wb_dat_t new_val,
    input wb_sel_t sel
  );
    wb_dat_t res;
    res = old_val;
    for (int b = 0; b < 4; b++)
    begin
      if (sel[b])
        res[8*b +: 8] = new_val[8*b +: 8];
    end
    return res;
  endfunction

  assign access  = bus.cyc & bus.stb & ~ack_q;
  assign wr_en   = access & bus.we;
  assign reg_ofs = {bus.adr[3:2], 2'b00};  // Bits 3:2 select the register

  // --------------------------------------------------------------------------
  // Registers and handshake
  // --------------------------------------------------------------------------
  always_ff @(posedge sysclk or posedge reset_switch)
  begin
    if (reset_switch)
    begin
      out_q     <= '0;
      oe_q      <= '0;
      aux_q     <= '0;
      in_meta_q <= '0;
      in_q      <= '0;
      ack_q     <= 1'b0;
    end
    else
    begin
      in_meta_q <= gpio_pad_i;
      in_q      <= in_meta_q;
      ack_q     <= access;                     // One-cycle ack
      if (wr_en)
      begin
        case (reg_ofs)
          GPIO_OUT_OFS: out_q <= lane_merge(out_q, bus.dat_w, bus.sel);
          GPIO_OE_OFS:  oe_q  <= lane_merge(oe_q, bus.dat_w, bus.sel);
          GPIO_AUX_OFS: aux_q <= lane_merge(aux_q, bus.dat_w, bus.sel);
          default:      ;                      // IN is read only
        endcase
      end
    end
  end

  // Read mux, stable while the host holds adr
  always_comb
  begin
    case (reg_ofs)
      GPIO_OUT_OFS: bus.dat_r = out_q;
      GPIO_OE_OFS:  bus.dat_r = oe_q;
      GPIO_AUX_OFS: bus.dat_r = aux_q;
      GPIO_IN_OFS:  bus.dat_r = in_q;
      default:      bus.dat_r = '0;
    endcase
  end

  assign bus.ack = ack_q;
  assign bus.err = 1'b0;        // Every offset is mapped

  // Pad outputs
  assign gpio_pad_o   = (aux_q & gpio_aux_i) | (~aux_q & out_q);
  assign gpio_padoe_o = oe_q;

endmodule

// File: verilog/soc_pkg.sv
// Shared types, address map and SRAM timing for the Wishbone SoC core
// Imported by every RTL module that needs a width or a map constant

package soc_pkg;

  // --------------------------------------------------------------------------
  // Bus and memory types
  // --------------------------------------------------------------------------
  typedef logic [31:0] wb_adr_t;     // Byte address
  typedef logic [31:0] wb_dat_t;     // Data word
  typedef logic [3:0]  wb_sel_t;     // Byte lane selects
  typedef logic [17:0] sram_adr_t;   // Halfword address, 256K deep
  typedef logic [15:0] sram_dat_t;   // SRAM data bus
  typedef logic [31:0] gpio_vec_t;   // One bit per pad
  typedef logic [3:0]  region_t;     // Address bits 23:20
  typedef logic [3:0]  reg_ofs_t;    // GPIO register byte offset

  // --------------------------------------------------------------------------
  // Address map
  // --------------------------------------------------------------------------
  localparam region_t REGION_SRAM = 4'h0;
  localparam region_t REGION_GPIO = 4'h1;

  localparam reg_ofs_t GPIO_OUT_OFS = 4'h0;  // Output value
  localparam reg_ofs_t GPIO_OE_OFS  = 4'h4;  // Output enable
  localparam reg_ofs_t GPIO_AUX_OFS = 4'h8;  // Aux select
  localparam reg_ofs_t GPIO_IN_OFS  = 4'hC;  // Synchronized pads, read only

  // --------------------------------------------------------------------------
  // SRAM timing
  // --------------------------------------------------------------------------
  localparam int SRAM_WAIT = 2;  // Extra cycles per halfword strobe

  // Wait counter sized to reach SRAM_WAIT
  typedef logic [$clog2(SRAM_WAIT+1)-1:0] sram_cnt_t;
  localparam sram_cnt_t SRAM_CNT_LAST = sram_cnt_t'(SRAM_WAIT);

  typedef enum logic [1:0] {
    IDLE,       // Waiting for a request
    LOW_HALF,   // Bits 15:0 on the SRAM bus
    HIGH_HALF,  // Bits 31:16 on the SRAM bus
    ACK         // One cycle of ack to the host
  } sram_state_t;

endpackage

// File: verilog/soc_top.sv
// SoC core top level with an external Wishbone host port in place of a CPU
// SRAM data and GPIO pads come out split, the board wrapper adds pad buffers

`timescale 1ns/1ns

module soc_top (
  input  logic               sysclk,
  input  logic               reset_switch,
  // Host port, Wishbone classic
  input  logic               host_cyc_i,
  input  logic               host_stb_i,
  input  logic               host_we_i,
  input  soc_pkg::wb_adr_t   host_adr_i,
  input  soc_pkg::wb_dat_t   host_dat_i,
  input  soc_pkg::wb_sel_t   host_sel_i,
  output soc_pkg::wb_dat_t   host_dat_o,
  output logic               host_ack_o,
  output logic               host_err_o,
  // GPIO pads
  input  soc_pkg::gpio_vec_t gpio_aux_i,
  input  soc_pkg::gpio_vec_t gpio_pad_i,
  output soc_pkg::gpio_vec_t gpio_pad_o,
  output soc_pkg::gpio_vec_t gpio_padoe_o,
  // SRAM pins
  output soc_pkg::sram_adr_t sram_addr_o,
  input  soc_pkg::sram_dat_t sram_dq_i,
  output soc_pkg::sram_dat_t sram_dq_o,
  output logic               sram_dq_oe_o,
  output logic               sram_ub_n_o,
  output logic               sram_lb_n_o,
  output logic               sram_we_n_o,
  output logic               sram_ce_n_o,
  output logic               sram_oe_n_o
);

  wb_if sram_bus ();  // Decoder to SRAM controller
  wb_if gpio_bus ();  // Decoder to GPIO port

  wb_decoder u_decoder (
    .sysclk       (sysclk),
    .reset_switch (reset_switch),
    .host_cyc_i   (host_cyc_i),
    .host_stb_i   (host_stb_i),
    .host_we_i    (host_we_i),
    .host_adr_i   (host_adr_i),
    .host_dat_i   (host_dat_i),
    .host_sel_i   (host_sel_i),
    .host_dat_o   (host_dat_o),
    .host_ack_o   (host_ack_o),
    .host_err_o   (host_err_o),
    .sram_bus     (sram_bus.master),
    .gpio_bus     (gpio_bus.master)
  );

  gpio_port u_gpio (
    .sysclk       (sysclk),
    .reset_switch (reset_switch),
    .bus          (gpio_bus.slave),
    .gpio_aux_i   (gpio_aux_i),
    .gpio_pad_i   (gpio_pad_i),
    .gpio_pad_o   (gpio_pad_o),
    .gpio_padoe_o (gpio_padoe_o)
  );

  sram_ctrl u_sram (
    .sysclk       (sysclk),
    .reset_switch (reset_switch),
    .bus          (sram_bus.slave),
    .sram_addr_o  (sram_addr_o),
    .sram_dq_i    (sram_dq_i),
    .sram_dq_o    (sram_dq_o),
    .sram_dq_oe_o (sram_dq_oe_o),
    .sram_ub_n_o  (sram_ub_n_o),
    .sram_lb_n_o  (sram_lb_n_o),
    .sram_we_n_o  (sram_we_n_o),
    .sram_ce_n_o  (sram_ce_n_o),
    .sram_oe_n_o  (sram_oe_n_o)
  );

endmodule

// File: verilog/sram_ctrl.sv
// Wishbone slave for a 16-bit asynchronous SRAM
// Each 32-bit access runs as a low then a high halfword cycle of fixed length

`timescale 1ns/1ns

module sram_ctrl (
  input  logic               sysclk,
  input  logic               reset_switch,
  wb_if.slave                bus,
  output soc_pkg::sram_adr_t sram_addr_o,
  input  soc_pkg::sram_dat_t sram_dq_i,
  output soc_pkg::sram_dat_t sram_dq_o,
  output logic               sram_dq_oe_o,
  output logic               sram_ub_n_o,
  output logic               sram_lb_n_o,
  output logic               sram_we_n_o,
  output logic               sram_ce_n_o,
  output logic               sram_oe_n_o
);
  import soc_pkg::*;

  sram_state_t state_q;
  sram_cnt_t   cnt_q;       // Cycles spent in the current halfword
  wb_dat_t     rd_q;        // Assembled read word
  logic        in_half;     // Either halfword window
  logic        is_high;
  logic [1:0]  half_sel;    // Byte selects of the current halfword
  logic        half_act;    // Halfword has at least one lane
  logic        last_cyc;    // Final cycle of a window

  assign is_high  = (state_q == HIGH_HALF);
  assign in_half  = (state_q == LOW_HALF) | is_high;
  assign half_sel = is_high ? bus.sel[3:2] : bus.sel[1:0];
  assign half_act = in_half & (|half_sel);
  assign last_cyc = (cnt_q == SRAM_CNT_LAST);

  // --------------------------------------------------------------------------
  // Sequencer
  // --------------------------------------------------------------------------
  always_ff @(posedge sysclk or posedge reset_switch)
  begin
    if (reset_switch)
    begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end
    else
    begin
      case (state_q)
        IDLE:
        begin
          cnt_q <= '0;
          if (bus.cyc & bus.stb)
            state_q <= LOW_HALF;
        end
        LOW_HALF, HIGH_HALF:
        begin
          if (last_cyc)
          begin
            cnt_q   <= '0;
            state_q <= is_high ? ACK : HIGH_HALF;
          end
          else
            cnt_q <= cnt_q + sram_cnt_t'(1);
        end
        default: state_q <= IDLE;             // ACK lasts one cycle
      endcase
    end
  end

  // Capture each halfword at the end of its window
  always_ff @(posedge sysclk)
  begin
    if (in_half & last_cyc & ~bus.we)
    begin
      if (is_high)
        rd_q[31:16] <= sram_dq_i;
      else
        rd_q[15:0]  <= sram_dq_i;
    end
  end

  // --------------------------------------------------------------------------
  // SRAM pins decoded from state
  // --------------------------------------------------------------------------
  assign sram_addr_o  = {bus.adr[18:2], is_high};   // Word index, halfword bit
  assign sram_dq_o    = is_high ? bus.dat_w[31:16] : bus.dat_w[15:0];
  assign sram_ce_n_o  = ~half_act;                  // Skipped halfword stays off
  assign sram_ub_n_o  = ~(half_act & half_sel[1]);
  assign sram_lb_n_o  = ~(half_act & half_sel[0]);
  assign sram_oe_n_o  = ~(half_act & ~bus.we);
  // we_n rises one cycle before the window ends so data outlasts it
  assign sram_we_n_o  = ~(half_act & bus.we & ~last_cyc);
  assign sram_dq_oe_o = half_act & bus.we;

  // Bus response
  assign bus.dat_r = rd_q;
  assign bus.ack   = (state_q == ACK);
  assign bus.err   = 1'b0;

endmodule

// File: verilog/wb_decoder.sv
// Routes the external host bus to the SRAM or GPIO slave by address region
// Unmapped regions end with a one-cycle err and zero read data

`timescale 1ns/1ns

module wb_decoder (
  input  logic             sysclk,
  input  logic             reset_switch,
  input  logic             host_cyc_i,
  input  logic             host_stb_i,
  input  logic             host_we_i,
  input  soc_pkg::wb_adr_t host_adr_i,
  input  soc_pkg::wb_dat_t host_dat_i,
  input  soc_pkg::wb_sel_t host_sel_i,
  output soc_pkg::wb_dat_t host_dat_o,
  output logic             host_ack_o,
  output logic             host_err_o,
  wb_if.master             sram_bus,
  wb_if.master             gpio_bus
);
  import soc_pkg::*;

  region_t region;     // Bits 23:20 of the host address
  logic    hit_sram;
  logic    hit_gpio;
  logic    unmapped;
  logic    err_q;      // Local err for unmapped accesses

  assign region   = host_adr_i[23:20];
  assign hit_sram = (region == REGION_SRAM);
  assign hit_gpio = (region == REGION_GPIO);
  assign unmapped = ~hit_sram & ~hit_gpio;

  // --------------------------------------------------------------------------
  // Request fan-out, stb reaches one slave only
  // --------------------------------------------------------------------------
  assign sram_bus.cyc   = host_cyc_i;
  assign sram_bus.stb   = host_stb_i & hit_sram;
  assign sram_bus.we    = host_we_i;
  assign sram_bus.adr   = host_adr_i;
  assign sram_bus.dat_w = host_dat_i;
  assign sram_bus.sel   = host_sel_i;

  assign gpio_bus.cyc   = host_cyc_i;
  assign gpio_bus.stb   = host_stb_i & hit_gpio;
  assign gpio_bus.we    = host_we_i;
  assign gpio_bus.adr   = host_adr_i;
  assign gpio_bus.dat_w = host_dat_i;
  assign gpio_bus.sel   = host_sel_i;

  // Err pulse, high for the cycle after stb is first sampled
  always_ff @(posedge sysclk or posedge reset_switch)
  begin
    if (reset_switch)
      err_q <= 1'b0;
    else
      err_q <= host_cyc_i & host_stb_i & unmapped & ~err_q;
  end

  // --------------------------------------------------------------------------
  // Response mux, same cycle as the slave
  // --------------------------------------------------------------------------
  always_comb
  begin
    host_dat_o = '0;                              // Unmapped reads return zero
    host_ack_o = 1'b0;
    host_err_o = err_q;
    if (hit_sram)
    begin
      host_dat_o = sram_bus.dat_r;
      host_ack_o = sram_bus.ack;
      host_err_o = sram_bus.err;
    end
    else if (hit_gpio)
    begin
      host_dat_o = gpio_bus.dat_r;
      host_ack_o = gpio_bus.ack;
      host_err_o = gpio_bus.err;
    end
  end

endmodule

// File: verilog/wb_if.sv
// Wishbone classic bus bundle between the decoder and one slave
// The decoder takes the master side, the slave takes the slave side

`timescale 1ns/1ns

interface wb_if;
  import soc_pkg::*;

  // Request, driven by the master
  logic    cyc;
  logic    stb;
  logic    we;
  wb_adr_t adr;
  wb_dat_t dat_w;
  wb_sel_t sel;

  // Response, driven by the slave
  wb_dat_t dat_r;
  logic    ack;
  logic    err;

  modport master (
    output cyc, stb, we, adr, dat_w, sel,
    input  dat_r, ack, err
  );

  modport slave (
    input  cyc, stb, we, adr, dat_w, sel,
    output dat_r, ack, err
  );

endinterface
